// File: hw/issue_pkg.sv
// Issue subsystem package: shared data widths, tag width and ALU opcode encoding
`default_nettype none

package issue_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int unsigned XLEN        = 32;   // Integer data width
    localparam int unsigned ILEN        = 32;   // Instruction width
    localparam int unsigned REG_IDX_LEN = 5;    // x0..x31
    localparam int unsigned TAG_LEN     = 4;    // Up to 16 instructions in flight

    // ------------------------------------------------------------------
    // ALU operations carried from the decoder to the stations
    // ------------------------------------------------------------------
    typedef enum logic [2:0] {
        ALU_ADD,        // ADD and ADDI
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_ILLEGAL     // Unsupported encoding, reported on the CDB
    } alu_op_t;

endpackage

`default_nettype wire

// File: hw/issue_queue.sv
// Issue queue: circular FIFO holding fetched instructions until the issue logic takes them
`default_nettype none

module issue_queue import issue_pkg::*; #(
    parameter int unsigned IQ_DEPTH = 4     // Power of two
) (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // Fetch side
    input  logic            fetch_valid_i,
    output logic            fetch_ready_o,
    input  logic [ILEN-1:0] fetch_instr_i,

    // Issue logic side
    output logic            issue_valid_o,
    input  logic            issue_ready_i,
    output logic [ILEN-1:0] instr_o
);

    localparam int unsigned PTR_W = $clog2(IQ_DEPTH);

    logic [ILEN-1:0]  mem_q [IQ_DEPTH];     // Instruction storage
    logic [PTR_W-1:0] head_q, tail_q;       // Read and write pointers, wrap on their own
    logic [PTR_W:0]   count_q;              // Number of valid entries
    logic             push, pop;

    assign fetch_ready_o = (count_q != IQ_DEPTH[PTR_W:0]);  // Full stops fetch
    assign issue_valid_o = (count_q != '0);
    assign instr_o       = mem_q[head_q];                   // Oldest entry

    assign push = fetch_valid_i & fetch_ready_o;
    assign pop  = issue_valid_o & issue_ready_i;

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) tail_q <= tail_q + 1'b1;
            if (pop)  head_q <= head_q + 1'b1;
            // Push and pop together leave the count unchanged
            if (push && !pop)      count_q <= count_q + 1'b1;
            else if (pop && !push) count_q <= count_q - 1'b1;
        end
    end

    // Storage write
    always_ff @(posedge clk_i) begin
        if (push) mem_q[tail_q] <= fetch_instr_i;
    end

endmodule

`default_nettype wire

// File: hw/reg_status_file.sv
// Integer register file with per-register busy bit and producer tag, written back from the CDB
`default_nettype none

module reg_status_file import issue_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    // Source reads
    input  logic [REG_IDX_LEN-1:0] rs1_idx_i,
    input  logic [REG_IDX_LEN-1:0] rs2_idx_i,
    output logic [XLEN-1:0]        rs1_value_o,
    output logic [XLEN-1:0]        rs2_value_o,
    output logic                   rs1_busy_o,
    output logic                   rs2_busy_o,
    output logic [TAG_LEN-1:0]     rs1_tag_o,
    output logic [TAG_LEN-1:0]     rs2_tag_o,

    // Destination allocation at dispatch
    input  logic                   alloc_valid_i,
    input  logic [REG_IDX_LEN-1:0] alloc_rd_i,
    input  logic [TAG_LEN-1:0]     alloc_tag_i,

    // CDB writeback, valid only on a handshake
    input  logic                   cdb_valid_i,
    input  logic [TAG_LEN-1:0]     cdb_tag_i,
    input  logic [XLEN-1:0]        cdb_value_i,
    input  logic                   cdb_except_i
);

    localparam int unsigned NREG = 1 << REG_IDX_LEN;

    logic [XLEN-1:0]    regs_q [NREG];
    logic [NREG-1:0]    busy_q;                 // Value still being computed
    logic [TAG_LEN-1:0] tag_q  [NREG];          // Latest producer of each register

    // Combinational reads, x0 is never written so it reads zero and idle
    assign rs1_value_o = regs_q[rs1_idx_i];
    assign rs2_value_o = regs_q[rs2_idx_i];
    assign rs1_busy_o  = busy_q[rs1_idx_i];
    assign rs2_busy_o  = busy_q[rs2_idx_i];
    assign rs1_tag_o   = tag_q[rs1_idx_i];
    assign rs2_tag_o   = tag_q[rs2_idx_i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NREG; i++) begin
                regs_q[i] <= '0;
                busy_q[i] <= 1'b0;
                tag_q[i]  <= '0;
            end
        end else begin
            // Writeback only from the newest producer, older writers are dropped
            for (int i = 1; i < NREG; i++) begin
                if (cdb_valid_i && !cdb_except_i && busy_q[i] && (tag_q[i] == cdb_tag_i)) begin
                    regs_q[i] <= cdb_value_i;
                    busy_q[i] <= 1'b0;
                end
            end
            // Allocation comes last so it overrides a same-cycle writeback
            if (alloc_valid_i && (alloc_rd_i != '0)) begin
                busy_q[alloc_rd_i] <= 1'b1;
                tag_q[alloc_rd_i]  <= alloc_tag_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/issue_logic.sv
// Issue logic: decodes, gathers operands with CDB bypass, allocates tags and dispatches to a free station
`default_nettype none

module issue_logic import issue_pkg::*; #(
    parameter int unsigned EU_N = 3
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    // Issue queue
    input  logic                   iq_valid_i,
    output logic                   iq_ready_o,
    input  logic [ILEN-1:0]        iq_instr_i,

    // Register status file
    output logic [REG_IDX_LEN-1:0] rs1_idx_o,
    output logic [REG_IDX_LEN-1:0] rs2_idx_o,
    input  logic [XLEN-1:0]        rs1_value_i,
    input  logic [XLEN-1:0]        rs2_value_i,
    input  logic                   rs1_busy_i,
    input  logic                   rs2_busy_i,
    input  logic [TAG_LEN-1:0]     rs1_tag_i,
    input  logic [TAG_LEN-1:0]     rs2_tag_i,
    output logic                   alloc_valid_o,
    output logic [REG_IDX_LEN-1:0] alloc_rd_o,
    output logic [TAG_LEN-1:0]     alloc_tag_o,

    // Reservation stations
    input  logic [EU_N-1:0]        rs_free_i,
    output logic [EU_N-1:0]        rs_valid_o,     // One-hot dispatch strobe
    output alu_op_t                ex_op_o,
    output logic                   ex_rs1_ready_o,
    output logic [TAG_LEN-1:0]     ex_rs1_tag_o,
    output logic [XLEN-1:0]        ex_rs1_value_o,
    output logic                   ex_rs2_ready_o,
    output logic [TAG_LEN-1:0]     ex_rs2_tag_o,
    output logic [XLEN-1:0]        ex_rs2_value_o,
    output logic [TAG_LEN-1:0]     ex_tag_o,

    // CDB snoop
    input  logic                   cdb_valid_i,
    input  logic                   cdb_ready_i,
    input  logic [TAG_LEN-1:0]     cdb_tag_i,
    input  logic [XLEN-1:0]        cdb_value_i
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;   // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;   // Register-immediate ALU
    localparam logic [TAG_LEN:0] MAX_INFLIGHT = {1'b1, {TAG_LEN{1'b0}}};

    logic [TAG_LEN-1:0] tag_cnt_q;          // Next tag to hand out
    logic [TAG_LEN:0]   inflight_q;         // Dispatched but not yet on the CDB
    logic               cdb_fire, dispatch, is_imm, is_illegal;
    logic               rs1_hit, rs2_hit, found;
    logic [EU_N-1:0]    free_sel;
    logic [XLEN-1:0]    imm;

    assign cdb_fire = cdb_valid_i & cdb_ready_i;

    // ------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------
    always_comb begin
        ex_op_o = ALU_ILLEGAL;
        is_imm  = 1'b0;
        case (iq_instr_i[6:0])
            OPC_OP: begin
                if (iq_instr_i[31:25] == 7'b0000000) begin
                    case (iq_instr_i[14:12])
                        3'b000:  ex_op_o = ALU_ADD;
                        3'b100:  ex_op_o = ALU_XOR;
                        3'b110:  ex_op_o = ALU_OR;
                        3'b111:  ex_op_o = ALU_AND;
                        default: ex_op_o = ALU_ILLEGAL;
                    endcase
                end else if (iq_instr_i[31:25] == 7'b0100000 && iq_instr_i[14:12] == 3'b000) begin
                    ex_op_o = ALU_SUB;
                end
            end
            OPC_OP_IMM: begin
                if (iq_instr_i[14:12] == 3'b000) begin  // ADDI only
                    ex_op_o = ALU_ADD;
                    is_imm  = 1'b1;
                end
            end
            default: ex_op_o = ALU_ILLEGAL;
        endcase
    end

    assign is_illegal = (ex_op_o == ALU_ILLEGAL);
    assign imm        = {{(XLEN-12){iq_instr_i[31]}}, iq_instr_i[31:20]};  // Sign-extended I-imm
    assign rs1_idx_o  = iq_instr_i[19:15];
    assign rs2_idx_o  = iq_instr_i[24:20];

    // ------------------------------------------------------------------
    // Operands, a same-cycle broadcast of the producer is bypassed
    // ------------------------------------------------------------------
    assign rs1_hit = cdb_fire & rs1_busy_i & (rs1_tag_i == cdb_tag_i);
    assign rs2_hit = cdb_fire & rs2_busy_i & (rs2_tag_i == cdb_tag_i);

    assign ex_rs1_ready_o = is_illegal | ~rs1_busy_i | rs1_hit;   // Illegal needs no operands
    assign ex_rs1_tag_o   = rs1_tag_i;
    assign ex_rs1_value_o = rs1_hit ? cdb_value_i : rs1_value_i;

    assign ex_rs2_ready_o = is_illegal | is_imm | ~rs2_busy_i | rs2_hit;
    assign ex_rs2_tag_o   = rs2_tag_i;
    assign ex_rs2_value_o = is_imm ? imm : (rs2_hit ? cdb_value_i : rs2_value_i);

    // ------------------------------------------------------------------
    // Station selection and dispatch
    // ------------------------------------------------------------------
    always_comb begin
        free_sel = '0;
        found    = 1'b0;
        for (int i = 0; i < EU_N; i++) begin
            if (rs_free_i[i] && !found) begin   // Lowest index wins
                free_sel[i] = 1'b1;
                found       = 1'b1;
            end
        end
    end

    assign iq_ready_o    = found && (inflight_q != MAX_INFLIGHT);
    assign dispatch      = iq_valid_i & iq_ready_o;
    assign rs_valid_o    = dispatch ? free_sel : '0;
    assign ex_tag_o      = tag_cnt_q;
    assign alloc_valid_o = dispatch & ~is_illegal;  // Illegal ops leave rd untouched
    assign alloc_rd_o    = iq_instr_i[11:7];
    assign alloc_tag_o   = tag_cnt_q;

    // Tag counter and in-flight count
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tag_cnt_q  <= '0;
            inflight_q <= '0;
        end else begin
            if (dispatch) tag_cnt_q <= tag_cnt_q + 1'b1;    // Wraps at 16
            if (dispatch && !cdb_fire)      inflight_q <= inflight_q + 1'b1;
            else if (cdb_fire && !dispatch) inflight_q <= inflight_q - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/reservation_station.sv
// Reservation station: one entry that waits on the CDB for operands, runs its ALU and holds the result
`default_nettype none

module reservation_station import issue_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // Dispatch from the issue logic
    input  logic               rs_valid_i,
    output logic               rs_free_o,
    input  alu_op_t            ex_op_i,
    input  logic               ex_rs1_ready_i,
    input  logic [TAG_LEN-1:0] ex_rs1_tag_i,
    input  logic [XLEN-1:0]    ex_rs1_value_i,
    input  logic               ex_rs2_ready_i,
    input  logic [TAG_LEN-1:0] ex_rs2_tag_i,
    input  logic [XLEN-1:0]    ex_rs2_value_i,
    input  logic [TAG_LEN-1:0] ex_tag_i,

    // CDB snoop
    input  logic               cdb_valid_i,
    input  logic               cdb_ready_i,
    input  logic [TAG_LEN-1:0] cdb_tag_i,
    input  logic [XLEN-1:0]    cdb_value_i,

    // Result towards the arbiter
    output logic               res_valid_o,
    output logic [TAG_LEN-1:0] res_tag_o,
    output logic [XLEN-1:0]    res_value_o,
    output logic               res_except_o,
    input  logic               grant_i
);

    typedef enum logic [1:0] {EMPTY, WAIT_OPS, DONE} state_t;

    state_t             state_q;
    alu_op_t            op_q, op_n;
    logic               a_rdy_q, b_rdy_q, a_rdy_n, b_rdy_n;
    logic [TAG_LEN-1:0] a_tag_q, b_tag_q, a_tag_n, b_tag_n;
    logic [XLEN-1:0]    a_q, b_q, a_n, b_n;
    logic [XLEN-1:0]    alu_res;
    logic               cdb_fire;

    assign cdb_fire = cdb_valid_i & cdb_ready_i;

    // Operand view for this cycle: fresh dispatch fields or the held entry plus snoop
    always_comb begin
        if (state_q == EMPTY) begin
            op_n    = ex_op_i;
            a_rdy_n = ex_rs1_ready_i;
            a_tag_n = ex_rs1_tag_i;
            a_n     = ex_rs1_value_i;
            b_rdy_n = ex_rs2_ready_i;
            b_tag_n = ex_rs2_tag_i;
            b_n     = ex_rs2_value_i;
        end else begin
            op_n    = op_q;
            a_tag_n = a_tag_q;
            b_tag_n = b_tag_q;
            a_rdy_n = a_rdy_q | (cdb_fire & (a_tag_q == cdb_tag_i));
            b_rdy_n = b_rdy_q | (cdb_fire & (b_tag_q == cdb_tag_i));
            a_n     = a_rdy_q ? a_q : cdb_value_i;      // Only used once ready
            b_n     = b_rdy_q ? b_q : cdb_value_i;
        end
    end

    // ALU
    always_comb begin
        case (op_n)
            ALU_ADD: alu_res = a_n + b_n;
            ALU_SUB: alu_res = a_n - b_n;
            ALU_AND: alu_res = a_n & b_n;
            ALU_OR:  alu_res = a_n | b_n;
            ALU_XOR: alu_res = a_n ^ b_n;
            default: alu_res = '0;                      // Illegal gives zero
        endcase
    end

    // ------------------------------------------------------------------
    // Entry FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= EMPTY;
        end else begin
            case (state_q)
                EMPTY:    if (rs_valid_i) state_q <= (a_rdy_n && b_rdy_n) ? DONE : WAIT_OPS;
                WAIT_OPS: if (a_rdy_n && b_rdy_n) state_q <= DONE;
                DONE:     if (grant_i) state_q <= EMPTY;  // Leaves on the CDB this cycle
                default:  state_q <= EMPTY;
            endcase
        end
    end

    // Payload, captured on dispatch and while waiting
    always_ff @(posedge clk_i) begin
        if ((state_q == EMPTY && rs_valid_i) || state_q == WAIT_OPS) begin
            op_q         <= op_n;
            a_rdy_q      <= a_rdy_n;
            a_tag_q      <= a_tag_n;
            a_q          <= a_n;
            b_rdy_q      <= b_rdy_n;
            b_tag_q      <= b_tag_n;
            b_q          <= b_n;
            res_value_o  <= alu_res;
            res_except_o <= (op_n == ALU_ILLEGAL);
        end
        if (state_q == EMPTY && rs_valid_i) res_tag_o <= ex_tag_i;
    end

    assign rs_free_o   = (state_q == EMPTY);
    assign res_valid_o = (state_q == DONE);

endmodule

`default_nettype wire

// File: hw/cdb_arbiter.sv
// CDB arbiter: round-robin choice among finished stations, one result broadcast per cycle
`default_nettype none

module cdb_arbiter import issue_pkg::*; #(
    parameter int unsigned EU_N = 3
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // Station results
    input  logic [EU_N-1:0]                 res_valid_i,
    input  logic [EU_N-1:0][TAG_LEN-1:0]    res_tag_i,
    input  logic [EU_N-1:0][XLEN-1:0]       res_value_i,
    input  logic [EU_N-1:0]                 res_except_i,
    output logic [EU_N-1:0]                 grant_o,        // One-hot

    // CDB
    output logic                            cdb_valid_o,
    input  logic                            cdb_ready_i,
    output logic [TAG_LEN-1:0]              cdb_tag_o,
    output logic [XLEN-1:0]                 cdb_value_o,
    output logic                            cdb_except_o
);

    localparam int unsigned IDX_W = (EU_N > 1) ? $clog2(EU_N) : 1;

    logic [IDX_W-1:0] last_q;       // Last granted station
    logic [IDX_W-1:0] lock_idx_q;   // Station held on the bus during back-pressure
    logic             locked_q;
    logic [IDX_W-1:0] pick, sel;
    logic             found;
    int unsigned      idx;

    // Round-robin search starting after the last grant
    always_comb begin
        pick  = '0;
        found = 1'b0;
        idx   = 0;
        for (int unsigned i = 1; i <= EU_N; i++) begin
            idx = (int'(last_q) + i) % EU_N;
            if (res_valid_i[idx] && !found) begin
                pick  = IDX_W'(idx);
                found = 1'b1;
            end
        end
    end

    // A stalled broadcast keeps its station so the bus stays stable
    assign sel          = locked_q ? lock_idx_q : pick;
    assign cdb_valid_o  = |res_valid_i;
    assign cdb_tag_o    = res_tag_i[sel];
    assign cdb_value_o  = res_value_i[sel];
    assign cdb_except_o = res_except_i[sel];

    always_comb begin
        grant_o = '0;
        if (cdb_valid_o && cdb_ready_i) grant_o[sel] = 1'b1;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_q     <= IDX_W'(EU_N - 1);   // First search starts at station 0
            lock_idx_q <= '0;
            locked_q   <= 1'b0;
        end else if (cdb_valid_o && cdb_ready_i) begin
            last_q   <= sel;
            locked_q <= 1'b0;
        end else if (cdb_valid_o) begin
            lock_idx_q <= sel;                // Ready low, hold this choice
            locked_q   <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/issue_stage.sv
// Issue stage top: issue queue, issue logic, register status file, reservation stations and CDB arbiter
`default_nettype none

module issue_stage import issue_pkg::*; #(
    parameter int unsigned EU_N     = 3,    // Reservation stations, 1 to 8
    parameter int unsigned IQ_DEPTH = 4     // Issue queue entries, power of two
) (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // Fetch
    input  logic               fetch_valid_i,
    output logic               fetch_ready_o,
    input  logic [ILEN-1:0]    fetch_instr_i,

    // CDB
    output logic               cdb_valid_o,
    input  logic               cdb_ready_i,
    output logic [TAG_LEN-1:0] cdb_tag_o,
    output logic [XLEN-1:0]    cdb_value_o,
    output logic               cdb_except_o
);

    // ------------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------------
    logic                   iq_il_valid, il_iq_ready;
    logic [ILEN-1:0]        iq_il_instr;

    logic [REG_IDX_LEN-1:0] rs1_idx, rs2_idx, alloc_rd;
    logic [XLEN-1:0]        rs1_value, rs2_value;
    logic                   rs1_busy, rs2_busy, alloc_valid;
    logic [TAG_LEN-1:0]     rs1_tag, rs2_tag, alloc_tag;

    logic [EU_N-1:0]        rs_free, rs_valid;          // Per-station dispatch handshake
    alu_op_t                ex_op;
    logic                   ex_rs1_ready, ex_rs2_ready;
    logic [TAG_LEN-1:0]     ex_rs1_tag, ex_rs2_tag, ex_tag;
    logic [XLEN-1:0]        ex_rs1_value, ex_rs2_value;

    logic [EU_N-1:0]              res_valid, res_except, grant;
    logic [EU_N-1:0][TAG_LEN-1:0] res_tag;
    logic [EU_N-1:0][XLEN-1:0]    res_value;

    issue_queue #(.IQ_DEPTH(IQ_DEPTH)) u_issue_queue (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_ready_o (fetch_ready_o),
        .fetch_instr_i (fetch_instr_i),
        .issue_valid_o (iq_il_valid),
        .issue_ready_i (il_iq_ready),
        .instr_o       (iq_il_instr)
    );

    issue_logic #(.EU_N(EU_N)) u_issue_logic (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .iq_valid_i     (iq_il_valid),
        .iq_ready_o     (il_iq_ready),
        .iq_instr_i     (iq_il_instr),
        .rs1_idx_o      (rs1_idx),
        .rs2_idx_o      (rs2_idx),
        .rs1_value_i    (rs1_value),
        .rs2_value_i    (rs2_value),
        .rs1_busy_i     (rs1_busy),
        .rs2_busy_i     (rs2_busy),
        .rs1_tag_i      (rs1_tag),
        .rs2_tag_i      (rs2_tag),
        .alloc_valid_o  (alloc_valid),
        .alloc_rd_o     (alloc_rd),
        .alloc_tag_o    (alloc_tag),
        .rs_free_i      (rs_free),
        .rs_valid_o     (rs_valid),
        .ex_op_o        (ex_op),
        .ex_rs1_ready_o (ex_rs1_ready),
        .ex_rs1_tag_o   (ex_rs1_tag),
        .ex_rs1_value_o (ex_rs1_value),
        .ex_rs2_ready_o (ex_rs2_ready),
        .ex_rs2_tag_o   (ex_rs2_tag),
        .ex_rs2_value_o (ex_rs2_value),
        .ex_tag_o       (ex_tag),
        .cdb_valid_i    (cdb_valid_o),
        .cdb_ready_i    (cdb_ready_i),
        .cdb_tag_i      (cdb_tag_o),
        .cdb_value_i    (cdb_value_o)
    );

    reg_status_file u_reg_status_file (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .rs1_idx_i     (rs1_idx),
        .rs2_idx_i     (rs2_idx),
        .rs1_value_o   (rs1_value),
        .rs2_value_o   (rs2_value),
        .rs1_busy_o    (rs1_busy),
        .rs2_busy_o    (rs2_busy),
        .rs1_tag_o     (rs1_tag),
        .rs2_tag_o     (rs2_tag),
        .alloc_valid_i (alloc_valid),
        .alloc_rd_i    (alloc_rd),
        .alloc_tag_i   (alloc_tag),
        .cdb_valid_i   (cdb_valid_o & cdb_ready_i),     // Writeback on handshake only
        .cdb_tag_i     (cdb_tag_o),
        .cdb_value_i   (cdb_value_o),
        .cdb_except_i  (cdb_except_o)
    );

    // ------------------------------------------------------------------
    // Reservation stations, dispatch fields shared and strobes per station
    // ------------------------------------------------------------------
    for (genvar g = 0; g < EU_N; g++) begin : g_rs
        reservation_station u_rs (
            .clk_i          (clk_i),
            .rst_n_i        (rst_n_i),
            .rs_valid_i     (rs_valid[g]),
            .rs_free_o      (rs_free[g]),
            .ex_op_i        (ex_op),
            .ex_rs1_ready_i (ex_rs1_ready),
            .ex_rs1_tag_i   (ex_rs1_tag),
            .ex_rs1_value_i (ex_rs1_value),
            .ex_rs2_ready_i (ex_rs2_ready),
            .ex_rs2_tag_i   (ex_rs2_tag),
            .ex_rs2_value_i (ex_rs2_value),
            .ex_tag_i       (ex_tag),
            .cdb_valid_i    (cdb_valid_o),
            .cdb_ready_i    (cdb_ready_i),
            .cdb_tag_i      (cdb_tag_o),
            .cdb_value_i    (cdb_value_o),
            .res_valid_o    (res_valid[g]),
            .res_tag_o      (res_tag[g]),
            .res_value_o    (res_value[g]),
            .res_except_o   (res_except[g]),
            .grant_i        (grant[g])
        );
    end

    cdb_arbiter #(.EU_N(EU_N)) u_cdb_arbiter (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .res_valid_i  (res_valid),
        .res_tag_i    (res_tag),
        .res_value_i  (res_value),
        .res_except_i (res_except),
        .grant_o      (grant),
        .cdb_valid_o  (cdb_valid_o),
        .cdb_ready_i  (cdb_ready_i),
        .cdb_tag_o    (cdb_tag_o),
        .cdb_value_o  (cdb_value_o),
        .cdb_except_o (cdb_except_o)
    );

endmodule

`default_nettype wire

// File: testbench/tb_issue_stage.sv
// Testbench for the issue stage that replays the test file and checks every CDB result by tag
`default_nettype none

module tb_issue_stage import issue_pkg::*; ();

    localparam int unsigned EU_N          = 3;
    localparam int unsigned IQ_DEPTH      = 4;
    localparam int          NUM_TESTS     = 20;             // Lines in the test file
    localparam int          NUM_TAGS      = 1 << TAG_LEN;
    localparam int          CLK_PERIOD    = 10;
    localparam int          FEED_TIMEOUT  = 2000;           // Cycles
    localparam int          DRAIN_TIMEOUT = 500;
    localparam int unsigned SEED          = 32'hd4c4e9bc;

    logic               clk_i, rst_n_i;
    logic               fetch_valid_i, fetch_ready_o;
    logic [ILEN-1:0]    fetch_instr_i;
    logic               cdb_valid_o, cdb_ready_i, cdb_except_o;
    logic [TAG_LEN-1:0] cdb_tag_o;
    logic [XLEN-1:0]    cdb_value_o;

    logic [31:0]        test_mem [3*NUM_TESTS];     // Instruction, result, exception per entry
    bit                 seen [NUM_TESTS];
    int                 round_q [NUM_TAGS];         // How often each tag has come back
    int                 n_seen, errors;
    int                 fetch_idx;                  // Instructions handed to the queue so far

    // Last stalled broadcast that must stay on the bus until taken
    logic               stall_q;
    logic [TAG_LEN-1:0] held_tag;
    logic [XLEN-1:0]    held_value;
    logic               held_except;

    issue_stage #(.EU_N(EU_N), .IQ_DEPTH(IQ_DEPTH)) uut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_ready_o (fetch_ready_o),
        .fetch_instr_i (fetch_instr_i),
        .cdb_valid_o   (cdb_valid_o),
        .cdb_ready_i   (cdb_ready_i),
        .cdb_tag_o     (cdb_tag_o),
        .cdb_value_o   (cdb_value_o),
        .cdb_except_o  (cdb_except_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------
    // Scoreboard where instruction n comes back with tag n mod 16
    // ------------------------------------------------------------------
    task automatic check_result(input logic [TAG_LEN-1:0] tag, input logic [XLEN-1:0] value,
                                input logic except);
        int idx;
        idx = int'(tag) + NUM_TAGS * round_q[tag];
        assert (idx < NUM_TESTS) else begin
            $display("Extra result on the CDB with tag %0d, no instruction left for it", tag);
            errors++;
        end
        if (idx < NUM_TESTS) begin
            assert (idx < fetch_idx) else begin
                $display("Tag %0d returned again before instruction %0d was fetched", tag, idx);
                errors++;
            end
            assert (value == test_mem[3*idx+1]) else begin
                $display("FAILED cdb_value_o (tag %h): got %h, expected %h",
                         tag, value, test_mem[3*idx+1]);
                errors++;
            end
            assert (except == test_mem[3*idx+2][0]) else begin
                $display("FAILED cdb_except_o (tag %h): got %h, expected %h",
                         tag, except, test_mem[3*idx+2][0]);
                errors++;
            end
            seen[idx] = 1'b1;
            n_seen++;
            round_q[tag]++;   // Next use of this tag belongs to instruction idx + 16
        end
    endtask

    // CDB monitor sampling on the rising edge where the handshake happens
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (stall_q) begin
                assert (cdb_valid_o) else begin
                    $display("cdb_valid_o dropped before the stalled result was taken");
                    errors++;
                end
                assert (cdb_tag_o == held_tag && cdb_value_o == held_value &&
                        cdb_except_o == held_except) else begin
                    $display("FAILED cdb_tag_o/cdb_value_o/cdb_except_o in stall: %s",
                             $sformatf("got %h/%h/%h, held %h/%h/%h",
                                       cdb_tag_o, cdb_value_o, cdb_except_o,
                                       held_tag, held_value, held_except));
                    errors++;
                end
            end
            if (cdb_valid_o && cdb_ready_i) check_result(cdb_tag_o, cdb_value_o, cdb_except_o);
            stall_q     = cdb_valid_o && !cdb_ready_i;
            held_tag    = cdb_tag_o;
            held_value  = cdb_value_o;
            held_except = cdb_except_o;
        end else begin
            stall_q = 1'b0;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        int unsigned seed_dummy;
        int          wait_cycles;
        logic        pending;           // Offered last cycle and not taken

        seed_dummy = $urandom(SEED);
        $readmemh("testbench/issue_tests.txt", test_mem);
        for (int i = 0; i < NUM_TESTS; i++) seen[i] = 1'b0;
        for (int t = 0; t < NUM_TAGS; t++) round_q[t] = 0;
        n_seen        = 0;
        errors        = 0;
        stall_q       = 1'b0;
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_instr_i = '0;
        cdb_ready_i   = 1'b0;
        fetch_idx     = 0;
        pending       = 1'b0;

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        assert (fetch_ready_o == 1'b1) else begin
            $display("FAILED fetch_ready_o after reset: got %h, expected %h",
                     fetch_ready_o, 1'b1);
            errors++;
        end
        assert (cdb_valid_o == 1'b0) else begin
            $display("FAILED cdb_valid_o after reset: got %h, expected %h",
                     cdb_valid_o, 1'b0);
            errors++;
        end

        // Feed with random gaps while CDB ready is low about one cycle in four
        wait_cycles = 0;
        while (fetch_idx < NUM_TESTS && wait_cycles < FEED_TIMEOUT) begin
            @(negedge clk_i);
            cdb_ready_i = (($urandom % 4) != 0);
            if (pending || (($urandom % 3) != 0)) begin
                fetch_valid_i = 1'b1;
                fetch_instr_i = test_mem[3*fetch_idx];
                pending       = !fetch_ready_o;       // Ready is stable until the next edge
                if (fetch_ready_o) fetch_idx++;
            end else begin
                fetch_valid_i = 1'b0;
            end
            wait_cycles++;
        end
        if (fetch_idx < NUM_TESTS) begin
            $display("Timeout while feeding, only %0d of %0d instructions accepted",
                     fetch_idx, NUM_TESTS);
            errors++;
        end

        @(negedge clk_i);
        fetch_valid_i = 1'b0;

        // Drain the remaining results
        wait_cycles = 0;
        while (n_seen < NUM_TESTS && wait_cycles < DRAIN_TIMEOUT) begin
            @(negedge clk_i);
            cdb_ready_i = (($urandom % 4) != 0);
            wait_cycles++;
        end
        if (n_seen < NUM_TESTS) begin
            $display("Timeout while draining, %0d of %0d results seen", n_seen, NUM_TESTS);
            errors++;
        end

        // Idle with ready high so that nothing more may show up
        cdb_ready_i = 1'b1;
        repeat (8) @(negedge clk_i);
        for (int i = 0; i < NUM_TESTS; i++) begin
            assert (seen[i]) else begin
                $display("Instruction %0d never came back on the CDB", i);
                errors++;
            end
        end

        $display("Run finished: %0d errors, %0d of %0d results seen", errors, n_seen, NUM_TESTS);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/issue_tests.txt
// Columns: instruction encoding, expected CDB value, expected exception flag (all hex)
// Expected values follow in-order execution from all-zero registers
00a00093 0000000a 0    // addi x1, x0, 10
ffd00113 fffffffd 0    // addi x2, x0, -3
55500193 00000555 0    // addi x3, x0, 0x555
0f000213 000000f0 0    // addi x4, x0, 0xf0
002082b3 00000007 0    // add  x5, x1, x2
40418333 00000465 0    // sub  x6, x3, x4
0041f3b3 00000050 0    // and  x7, x3, x4
0040e433 000000fa 0    // or   x8, x1, x4
003144b3 fffffaa8 0    // xor  x9, x2, x3
00528533 0000000e 0    // add  x10, x5, x5
fff50513 0000000d 0    // addi x10, x10, -1
00100593 00000001 0    // addi x11, x0, 1
00200593 00000002 0    // addi x11, x0, 2
00a58633 0000000f 0    // add  x12, x11, x10
00500013 00000005 0    // addi x0, x0, 5
001006b3 0000000a 0    // add  x13, x0, x1
022082b3 00000000 1    // mul  x5, x1, x2 is not supported
00028733 00000007 0    // add  x14, x5, x0
401007b3 fffffff6 0    // sub  x15, x0, x1
00a58633 0000000f 0    // add  x12, x11, x10

// File: verilog.f
hw/issue_pkg.sv
hw/issue_queue.sv
hw/reg_status_file.sv
hw/issue_logic.sv
hw/reservation_station.sv
hw/cdb_arbiter.sv
hw/issue_stage.sv
testbench/tb_issue_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_issue_stage
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_$(TOP)
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
